/* include/autotest_cfg.svh */
// Autotest configuration
// Widths, first SD block, execution timeout and the block signature
// shared by the autotest controller and its packages.

`ifndef AUTOTEST_CFG_SVH
`define AUTOTEST_CFG_SVH

// operand and result width in bits, a multiple of 8
`define AT_OPERAND_W 32

// execution cycle counter width
`define AT_TIMER_W 64

`define AT_START_BLOCK 32'h0010_0000

// kept small to bound simulation time
`define AT_TIMEOUT 64'd256

`define AT_SIGNATURE 32'hAABB_CCDD
`define AT_BLOCK_BYTES 512

`endif

/* hdl/sd_block_pkg.sv */
// SD test block layout
// Byte types, field offsets and the signature word of a 512-byte
// test vector block as read from and echoed back to the card.

`default_nettype none

`include "autotest_cfg.svh"

package sd_block_pkg;

  typedef logic [7:0] sd_byte_t;
  typedef logic [9:0] sd_offset_t;
  typedef logic [`AT_OPERAND_W-1:0] operand_t;

  localparam int SIG_BYTES = 4;
  localparam int OP_BYTES = `AT_OPERAND_W / 8;
  localparam int CYC_BYTES = 8;

  // signature arrives byte by byte, checked as one word
  typedef union packed {
    logic [31:0] word;
    sd_byte_t [SIG_BYTES-1:0] bytes;
  } sig_word_u;

  // signature msb first, all other fields lsb first
  localparam sd_offset_t OFS_SIG = 10'd0;
  localparam sd_offset_t OFS_OPA = 10'd4;
  localparam sd_offset_t OFS_OPB = 10'd8;
  localparam sd_offset_t OFS_EXP = 10'd12;
  localparam sd_offset_t OFS_RES = 10'd16;
  localparam sd_offset_t OFS_CYC = 10'd20;
  localparam sd_offset_t OFS_LAST = sd_offset_t'(`AT_BLOCK_BYTES - 1);

endpackage

`default_nettype wire

/* hdl/autotest_pkg.sv */
// Autotest controller types
// Sequencer state encoding and the execution cycle count type.

`default_nettype none

`include "autotest_cfg.svh"

package autotest_pkg;

  typedef enum logic [4:0] {
    ST_IDLE,
    ST_HOST_RST,
    ST_HOST_WAIT,
    ST_RD_OPEN,
    ST_RD_OPEN_WAIT,
    ST_RD_BYTE,
    ST_RD_WAIT,
    ST_SIG_CHECK,
    ST_EXEC,
    ST_COMPARE,
    ST_WR_OPEN,
    ST_WR_OPEN_WAIT,
    ST_WR_BYTE,
    ST_WR_WAIT,
    ST_NEXT_BLOCK
  } at_state_t;

  typedef logic [`AT_TIMER_W-1:0] cycle_count_t;

endpackage

`default_nettype wire

/* hdl/vector_store.sv */
// Test vector store
// Holds the signature, operands and expected value loaded byte by byte
// from an SD block, latches the UUT result and selects the echo byte.

`timescale 1ns/10ps
`default_nettype none

`include "autotest_cfg.svh"

module vector_store (
  input  logic                      clk,
  input  logic                      clear_i,
  input  logic                      load_i,
  input  sd_block_pkg::sd_offset_t  offset_i,
  input  sd_block_pkg::sd_byte_t    load_byte_i,
  input  logic                      capture_i,
  input  sd_block_pkg::operand_t    uut_result_i,
  input  autotest_pkg::cycle_count_t cycles_i,
  output logic                      sig_ok_o,
  output logic                      result_match_o,
  output sd_block_pkg::operand_t    operand_a_o,
  output sd_block_pkg::operand_t    operand_b_o,
  output sd_block_pkg::sd_byte_t    wb_byte_o
);

  import sd_block_pkg::*;

  sig_word_u sig_q;
  operand_t opa_q;
  operand_t opb_q;
  operand_t exp_q;
  operand_t res_q;

  logic [SIG_BYTES-1:0] sig_we;
  logic [OP_BYTES-1:0] opa_we;
  logic [OP_BYTES-1:0] opb_we;
  logic [OP_BYTES-1:0] exp_we;

  // byte enables straight from the offset
  always_comb begin
    for (int b = 0; b < SIG_BYTES; b++) begin
      sig_we[b] = load_i && (offset_i == OFS_SIG + b);
    end
    for (int b = 0; b < OP_BYTES; b++) begin
      opa_we[b] = load_i && (offset_i == OFS_OPA + b);
      opb_we[b] = load_i && (offset_i == OFS_OPB + b);
      exp_we[b] = load_i && (offset_i == OFS_EXP + b);
    end
  end

  always_ff @(posedge clk) begin
    if (clear_i) begin
      sig_q <= '0;
      opa_q <= '0;
      opb_q <= '0;
      exp_q <= '0;
      res_q <= '0;
    end else begin
      for (int b = 0; b < SIG_BYTES; b++) begin
        if (sig_we[b]) begin
          sig_q.bytes[SIG_BYTES-1-b] <= load_byte_i;
        end
      end
      for (int b = 0; b < OP_BYTES; b++) begin
        if (opa_we[b]) begin
          opa_q[8*b +: 8] <= load_byte_i;
        end
        if (opb_we[b]) begin
          opb_q[8*b +: 8] <= load_byte_i;
        end
        if (exp_we[b]) begin
          exp_q[8*b +: 8] <= load_byte_i;
        end
      end
      if (capture_i) begin
        res_q <= uut_result_i;
      end
    end
  end

  // echo byte, padding past the cycle field
  always_comb begin
    wb_byte_o = 8'hFF;
    for (int b = 0; b < SIG_BYTES; b++) begin
      if (offset_i == OFS_SIG + b) begin
        wb_byte_o = sig_q.bytes[SIG_BYTES-1-b];
      end
    end
    for (int b = 0; b < OP_BYTES; b++) begin
      if (offset_i == OFS_OPA + b) begin
        wb_byte_o = opa_q[8*b +: 8];
      end else if (offset_i == OFS_OPB + b) begin
        wb_byte_o = opb_q[8*b +: 8];
      end else if (offset_i == OFS_EXP + b) begin
        wb_byte_o = exp_q[8*b +: 8];
      end else if (offset_i == OFS_RES + b) begin
        wb_byte_o = res_q[8*b +: 8];
      end
    end
    for (int b = 0; b < CYC_BYTES; b++) begin
      if (offset_i == OFS_CYC + b) begin
        wb_byte_o = cycles_i[8*b +: 8];
      end
    end
  end

  assign sig_ok_o = (sig_q.word == `AT_SIGNATURE);
  assign result_match_o = (res_q == exp_q);
  assign operand_a_o = opa_q;
  assign operand_b_o = opb_q;

endmodule

`default_nettype wire

/* hdl/exec_timer.sv */
// Execution timer
// Counts UUT execution cycles and flags a run that exceeds the
// configured timeout.

`timescale 1ns/10ps
`default_nettype none

`include "autotest_cfg.svh"

module exec_timer (
  input  logic                       clk,
  input  logic                       clear_i,
  input  logic                       run_i,
  output autotest_pkg::cycle_count_t cycles_o,
  output logic                       timeout_o
);

  // holds its value between runs so the count can be echoed
  always_ff @(posedge clk) begin
    if (clear_i) begin
      cycles_o <= '0;
    end else if (run_i) begin
      cycles_o <= cycles_o + 1'b1;
    end
  end

  assign timeout_o = (cycles_o > `AT_TIMEOUT);

endmodule

`default_nettype wire

/* hdl/autotest_fsm.sv */
// Autotest sequencer
// Resets the SD host, reads each test block, runs the UUT with a
// timeout, counts result mismatches and writes the echo block back.
// Stops at the first block without a valid signature.

`timescale 1ns/10ps
`default_nettype none

`include "autotest_cfg.svh"

module autotest_fsm (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start_i,
  input  logic                     spi_busy_i,
  output logic                     spi_r_block_o,
  output logic                     spi_r_byte_o,
  output logic                     spi_w_block_o,
  output logic                     spi_w_byte_o,
  output logic                     spi_rst_o,
  output logic [31:0]              spi_block_addr_o,
  output logic                     uut_rst_o,
  input  logic                     uut_done_i,
  input  logic                     sig_ok_i,
  input  logic                     result_match_i,
  input  logic                     timeout_i,
  output logic                     store_clear_o,
  output logic                     load_o,
  output logic                     capture_o,
  output sd_block_pkg::sd_offset_t offset_o,
  output logic                     timer_clear_o,
  output logic                     timer_run_o,
  output logic [31:0]              error_count_o,
  output logic                     active_o
);

  import sd_block_pkg::*;
  import autotest_pkg::*;

  at_state_t state_q;
  at_state_t state_d;

  logic [31:0] block_addr_q;
  sd_offset_t offset_q;
  logic [31:0] err_q;

  logic blk_init;
  logic blk_inc;
  logic offset_clr;
  logic offset_inc;
  logic err_inc;

  always_comb begin
    state_d = state_q;
    spi_r_block_o = 1'b0;
    spi_r_byte_o = 1'b0;
    spi_w_block_o = 1'b0;
    spi_w_byte_o = 1'b0;
    spi_rst_o = 1'b0;
    uut_rst_o = 1'b1;
    store_clear_o = 1'b0;
    load_o = 1'b0;
    capture_o = 1'b0;
    timer_clear_o = 1'b0;
    timer_run_o = 1'b0;
    blk_init = 1'b0;
    blk_inc = 1'b0;
    offset_clr = 1'b0;
    offset_inc = 1'b0;
    err_inc = 1'b0;

    unique case (state_q)
      ST_IDLE: begin
        uut_rst_o = 1'b0;
        store_clear_o = 1'b1;
        timer_clear_o = 1'b1;
        if (start_i) begin
          blk_init = 1'b1;
          state_d = ST_HOST_RST;
        end
      end
      ST_HOST_RST: begin
        spi_rst_o = 1'b1;
        if (spi_busy_i) begin
          state_d = ST_HOST_WAIT;
        end
      end
      ST_HOST_WAIT: begin
        if (!spi_busy_i) begin
          state_d = ST_RD_OPEN;
        end
      end
      // host goes busy while it opens a block
      ST_RD_OPEN: begin
        spi_r_block_o = 1'b1;
        store_clear_o = 1'b1;
        timer_clear_o = 1'b1;
        offset_clr = 1'b1;
        if (spi_busy_i) begin
          state_d = ST_RD_OPEN_WAIT;
        end
      end
      ST_RD_OPEN_WAIT: begin
        spi_r_block_o = 1'b1;
        if (!spi_busy_i) begin
          state_d = ST_RD_BYTE;
        end
      end
      ST_RD_BYTE: begin
        spi_r_block_o = 1'b1;
        spi_r_byte_o = 1'b1;
        if (spi_busy_i) begin
          state_d = ST_RD_WAIT;
        end
      end
      ST_RD_WAIT: begin
        spi_r_block_o = 1'b1;
        if (!spi_busy_i) begin
          // data byte valid as busy drops
          load_o = 1'b1;
          if (offset_q == OFS_LAST) begin
            state_d = ST_SIG_CHECK;
          end else begin
            offset_inc = 1'b1;
            state_d = ST_RD_BYTE;
          end
        end
      end
      ST_SIG_CHECK: begin
        state_d = sig_ok_i ? ST_EXEC : ST_IDLE;
      end
      ST_EXEC: begin
        uut_rst_o = 1'b0;
        timer_run_o = 1'b1;
        if (uut_done_i || timeout_i) begin
          capture_o = 1'b1;
          state_d = ST_COMPARE;
        end
      end
      ST_COMPARE: begin
        err_inc = !result_match_i;
        offset_clr = 1'b1;
        state_d = ST_WR_OPEN;
      end
      ST_WR_OPEN: begin
        spi_w_block_o = 1'b1;
        if (spi_busy_i) begin
          state_d = ST_WR_OPEN_WAIT;
        end
      end
      ST_WR_OPEN_WAIT: begin
        spi_w_block_o = 1'b1;
        if (!spi_busy_i) begin
          state_d = ST_WR_BYTE;
        end
      end
      ST_WR_BYTE: begin
        spi_w_block_o = 1'b1;
        spi_w_byte_o = 1'b1;
        if (spi_busy_i) begin
          state_d = ST_WR_WAIT;
        end
      end
      ST_WR_WAIT: begin
        spi_w_block_o = 1'b1;
        if (!spi_busy_i) begin
          if (offset_q == OFS_LAST) begin
            state_d = ST_NEXT_BLOCK;
          end else begin
            offset_inc = 1'b1;
            state_d = ST_WR_BYTE;
          end
        end
      end
      ST_NEXT_BLOCK: begin
        blk_inc = 1'b1;
        state_d = ST_RD_OPEN;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
      block_addr_q <= `AT_START_BLOCK;
      offset_q <= '0;
      err_q <= '0;
    end else begin
      state_q <= state_d;
      if (blk_init) begin
        block_addr_q <= `AT_START_BLOCK;
      end else if (blk_inc) begin
        block_addr_q <= block_addr_q + 32'd1;
      end
      if (offset_clr) begin
        offset_q <= '0;
      end else if (offset_inc) begin
        offset_q <= offset_q + 10'd1;
      end
      if (err_inc) begin
        err_q <= err_q + 32'd1;
      end
    end
  end

  assign spi_block_addr_o = block_addr_q;
  assign offset_o = offset_q;
  assign error_count_o = err_q;
  assign active_o = (state_q != ST_IDLE);

endmodule

`default_nettype wire

/* hdl/autotest_top.sv */
// SD card autotest controller
// Reads test vectors from an SPI SD host block by block, runs the UUT
// on each, counts mismatches and writes every result back to the card.

`timescale 1ns/10ps
`default_nettype none

module autotest_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start_i,
  input  logic                   spi_busy_i,
  input  sd_block_pkg::sd_byte_t spi_data_out_i,
  output logic [31:0]            spi_block_addr_o,
  output sd_block_pkg::sd_byte_t spi_data_in_o,
  output logic                   spi_r_block_o,
  output logic                   spi_r_byte_o,
  output logic                   spi_w_block_o,
  output logic                   spi_w_byte_o,
  output logic                   spi_rst_o,
  output logic                   uut_rst_o,
  input  logic                   uut_done_i,
  output sd_block_pkg::operand_t operand_a_o,
  output sd_block_pkg::operand_t operand_b_o,
  input  sd_block_pkg::operand_t uut_result_i,
  output logic [31:0]            error_count_o,
  output logic                   active_o
);

  import sd_block_pkg::*;
  import autotest_pkg::*;

  logic sig_ok;
  logic result_match;
  logic timeout;
  logic store_clear;
  logic load;
  logic capture;
  logic timer_clear;
  logic timer_run;
  sd_offset_t offset;
  cycle_count_t cycles;

  autotest_fsm autotest_fsm_inst (
    .clk              (clk),
    .rst              (rst),
    .start_i          (start_i),
    .spi_busy_i       (spi_busy_i),
    .spi_r_block_o    (spi_r_block_o),
    .spi_r_byte_o     (spi_r_byte_o),
    .spi_w_block_o    (spi_w_block_o),
    .spi_w_byte_o     (spi_w_byte_o),
    .spi_rst_o        (spi_rst_o),
    .spi_block_addr_o (spi_block_addr_o),
    .uut_rst_o        (uut_rst_o),
    .uut_done_i       (uut_done_i),
    .sig_ok_i         (sig_ok),
    .result_match_i   (result_match),
    .timeout_i        (timeout),
    .store_clear_o    (store_clear),
    .load_o           (load),
    .capture_o        (capture),
    .offset_o         (offset),
    .timer_clear_o    (timer_clear),
    .timer_run_o      (timer_run),
    .error_count_o    (error_count_o),
    .active_o         (active_o)
  );

  vector_store vector_store_inst (
    .clk            (clk),
    .clear_i        (store_clear),
    .load_i         (load),
    .offset_i       (offset),
    .load_byte_i    (spi_data_out_i),
    .capture_i      (capture),
    .uut_result_i   (uut_result_i),
    .cycles_i       (cycles),
    .sig_ok_o       (sig_ok),
    .result_match_o (result_match),
    .operand_a_o    (operand_a_o),
    .operand_b_o    (operand_b_o),
    .wb_byte_o      (spi_data_in_o)
  );

  exec_timer exec_timer_inst (
    .clk       (clk),
    .clear_i   (timer_clear),
    .run_i     (timer_run),
    .cycles_o  (cycles),
    .timeout_o (timeout)
  );

endmodule

`default_nettype wire

/* verification/sd_host_model.sv */
// SPI SD host model
// Busy-level handshake host with a small card image in memory.
// Logs the address of every block opened for writing.

`timescale 1ns/10ps
`default_nettype none

`include "autotest_cfg.svh"

module sd_host_model #(
  parameter int NUM_BLOCKS = 8
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   spi_rst_i,
  input  logic                   spi_r_block_i,
  input  logic                   spi_r_byte_i,
  input  logic                   spi_w_block_i,
  input  logic                   spi_w_byte_i,
  input  logic [31:0]            spi_block_addr_i,
  input  sd_block_pkg::sd_byte_t spi_data_in_i,
  output logic                   spi_busy_o,
  output sd_block_pkg::sd_byte_t spi_data_out_o
);

  import sd_block_pkg::*;

  localparam int MEM_BYTES = NUM_BLOCKS * `AT_BLOCK_BYTES;
  localparam int OP_CTRL = 0;
  localparam int OP_RD = 1;
  localparam int OP_WR = 2;

  sd_byte_t mem [0:MEM_BYTES-1];
  logic [31:0] wr_log [0:NUM_BLOCKS-1];
  int wr_count;
  int bad_access;
  int busy_left;
  int op;
  int base;
  int ptr;
  int xfer_count;
  logic rd_open;
  logic wr_open;

  initial begin
    spi_busy_o = 1'b0;
    spi_data_out_o = '0;
    wr_count = 0;
    bad_access = 0;
  end

  // busy lasts 2 to 4 cycles
  task automatic go_busy(input int kind);
    op = kind;
    busy_left = 2 + xfer_count % 3;
    xfer_count++;
    spi_busy_o = 1'b1;
  endtask

  task automatic open_block();
    logic [31:0] idx;
    idx = spi_block_addr_i - `AT_START_BLOCK;
    ptr = 0;
    base = 0;
    if (idx >= NUM_BLOCKS) begin
      bad_access++;
      $display("host model: block address %h outside the card image", spi_block_addr_i);
    end else begin
      base = idx * `AT_BLOCK_BYTES;
    end
  endtask

  always @(negedge clk) begin
    if (rst) begin
      spi_busy_o = 1'b0;
      busy_left = 0;
      rd_open = 1'b0;
      wr_open = 1'b0;
      ptr = 0;
      base = 0;
      xfer_count = 0;
    end else if (spi_busy_o) begin
      busy_left--;
      if (busy_left == 0) begin
        spi_busy_o = 1'b0;
        if (op != OP_CTRL && ptr >= `AT_BLOCK_BYTES) begin
          bad_access++;
          $display("host model: byte transfer past the end of block %h", spi_block_addr_i);
        end else if (op == OP_RD) begin
          spi_data_out_o = mem[base + ptr];
          ptr++;
        end else if (op == OP_WR) begin
          mem[base + ptr] = spi_data_in_i;
          ptr++;
        end
      end
    end else begin
      if (!spi_r_block_i) begin
        rd_open = 1'b0;
      end
      if (!spi_w_block_i) begin
        wr_open = 1'b0;
      end
      if (spi_rst_i) begin
        go_busy(OP_CTRL);
      end else if (spi_r_block_i && !rd_open) begin
        rd_open = 1'b1;
        open_block();
        go_busy(OP_CTRL);
      end else if (spi_w_block_i && !wr_open) begin
        wr_open = 1'b1;
        open_block();
        if (wr_count < NUM_BLOCKS) begin
          wr_log[wr_count] = spi_block_addr_i;
        end
        wr_count++;
        go_busy(OP_CTRL);
      end else if (spi_r_byte_i && rd_open) begin
        go_busy(OP_RD);
      end else if (spi_w_byte_i && wr_open) begin
        go_busy(OP_WR);
      end
    end
  end

endmodule

`default_nettype wire

/* verification/autotest_asserts.sv */
// Autotest sequencer assertions
// Block strobe exclusion, write data hold and UUT reset timing.

`timescale 1ns/10ps
`default_nettype none

module autotest_asserts (
  input logic                     clk,
  input logic                     rst,
  input logic                     spi_r_block_i,
  input logic                     spi_w_block_i,
  input logic                     spi_w_byte_i,
  input logic                     spi_busy_i,
  input sd_block_pkg::sd_offset_t offset_i,
  input logic                     uut_rst_i,
  input logic                     timer_run_i,
  input logic                     active_i
);

  int unsigned fail_count = 0;

  one_block_strobe: assert property (@(posedge clk) disable iff (rst)
    !(spi_r_block_i && spi_w_block_i))
    else begin
      fail_count++;
      $error("read and write block strobes high together");
    end

  // echo byte is selected by the offset, so the offset must hold
  write_byte_stable: assert property (@(posedge clk) disable iff (rst)
    (spi_w_block_i && (spi_w_byte_i || spi_busy_i)) |=> $stable(offset_i))
    else begin
      fail_count++;
      $error("write byte selection changed while the host was busy");
    end

  uut_rst_in_exec: assert property (@(posedge clk) disable iff (rst)
    (active_i && !uut_rst_i) |-> timer_run_i)
    else begin
      fail_count++;
      $error("UUT released while the execution timer was stopped");
    end

endmodule

bind autotest_fsm autotest_asserts asserts_inst (
  .clk           (clk),
  .rst           (rst),
  .spi_r_block_i (spi_r_block_o),
  .spi_w_block_i (spi_w_block_o),
  .spi_w_byte_i  (spi_w_byte_o),
  .spi_busy_i    (spi_busy_i),
  .offset_i      (offset_o),
  .uut_rst_i     (uut_rst_o),
  .timer_run_i   (timer_run_o),
  .active_i      (active_o)
);

`default_nettype wire

/* verification/autotest_tb.sv */
// Autotest controller testbench
// Preloads test blocks into the SD host model, runs the controller
// against an adder UUT model and checks the echoed blocks.

`timescale 1ns/10ps
`default_nettype none

`include "autotest_cfg.svh"

module autotest_tb;

  import sd_block_pkg::*;
  import autotest_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_BLOCKS = 8;
  localparam int NUM_TESTS = 5;
  localparam int MAX_BLOCKS = 4;
  localparam int WORST_CYCLES_PER_BYTE = 16;
  localparam longint WATCHDOG_NS =
    longint'(NUM_TESTS) * MAX_BLOCKS * 600 * WORST_CYCLES_PER_BYTE * CLK_PERIOD;
  localparam int BLK = `AT_BLOCK_BYTES;
  localparam logic [31:0] GOOD_SIG = `AT_SIGNATURE;
  localparam logic [31:0] BAD_SIG = 32'h1122_3344;

  logic clk;
  logic rst;
  logic start;
  logic spi_busy;
  sd_byte_t spi_data_out;
  logic [31:0] spi_block_addr;
  sd_byte_t spi_data_in;
  logic spi_r_block;
  logic spi_r_byte;
  logic spi_w_block;
  logic spi_w_byte;
  logic spi_rst;
  logic uut_rst;
  logic uut_done;
  operand_t operand_a;
  operand_t operand_b;
  operand_t uut_result;
  logic [31:0] error_count;
  logic active;

  int errors;
  int checks;
  int seed;
  int done_delay;
  int exec_cycles;
  logic uut_hang;

  autotest_top autotest_top_inst (
    .clk              (clk),
    .rst              (rst),
    .start_i          (start),
    .spi_busy_i       (spi_busy),
    .spi_data_out_i   (spi_data_out),
    .spi_block_addr_o (spi_block_addr),
    .spi_data_in_o    (spi_data_in),
    .spi_r_block_o    (spi_r_block),
    .spi_r_byte_o     (spi_r_byte),
    .spi_w_block_o    (spi_w_block),
    .spi_w_byte_o     (spi_w_byte),
    .spi_rst_o        (spi_rst),
    .uut_rst_o        (uut_rst),
    .uut_done_i       (uut_done),
    .operand_a_o      (operand_a),
    .operand_b_o      (operand_b),
    .uut_result_i     (uut_result),
    .error_count_o    (error_count),
    .active_o         (active)
  );

  sd_host_model #(
    .NUM_BLOCKS (NUM_BLOCKS)
  ) host_inst (
    .clk              (clk),
    .rst              (rst),
    .spi_rst_i        (spi_rst),
    .spi_r_block_i    (spi_r_block),
    .spi_r_byte_i     (spi_r_byte),
    .spi_w_block_i    (spi_w_block),
    .spi_w_byte_i     (spi_w_byte),
    .spi_block_addr_i (spi_block_addr),
    .spi_data_in_i    (spi_data_in),
    .spi_busy_o       (spi_busy),
    .spi_data_out_o   (spi_data_out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // adder UUT, done after a random delay unless told to hang
  always @(negedge clk) begin
    if (rst || uut_rst) begin
      uut_done <= 1'b0;
      uut_result <= '0;
      exec_cycles <= 0;
    end else begin
      if (exec_cycles == 0) begin
        done_delay = {$random(seed)} % 100;
      end
      exec_cycles <= exec_cycles + 1;
      if (!uut_hang && exec_cycles >= done_delay) begin
        uut_done <= 1'b1;
        uut_result <= operand_a + operand_b;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all tests finished");
    $display("Simulation failed");
    $finish;
  end

  task automatic check_byte(input string name, input sd_byte_t got, input sd_byte_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_operand(input string name, input operand_t got, input operand_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  function automatic logic [31:0] block_addr(input int idx);
    return `AT_START_BLOCK + idx;
  endfunction

  function automatic operand_t get_operand(input int blk, input int ofs);
    operand_t v;
    for (int i = 0; i < OP_BYTES; i++) begin
      v[8*i +: 8] = host_inst.mem[blk * BLK + ofs + i];
    end
    return v;
  endfunction

  function automatic cycle_count_t get_cycles(input int blk);
    cycle_count_t v;
    for (int i = 0; i < CYC_BYTES; i++) begin
      v[8*i +: 8] = host_inst.mem[blk * BLK + OFS_CYC + i];
    end
    return v;
  endfunction

  // fill follows the whole address, so stale bytes rarely match the padding
  task automatic fill_card();
    for (int i = 0; i < NUM_BLOCKS * BLK; i++) begin
      host_inst.mem[i] = sd_byte_t'(i) ^ sd_byte_t'(i >> 8) ^ 8'h5A;
    end
    host_inst.wr_count = 0;
  endtask

  task automatic put_vector(input int blk, input logic [31:0] sig, input operand_t a,
                            input operand_t b, input operand_t exp_val);
    int base;
    base = blk * BLK;
    for (int i = 0; i < 4; i++) begin
      host_inst.mem[base + OFS_SIG + i] = sig[8*(3-i) +: 8];
    end
    for (int i = 0; i < OP_BYTES; i++) begin
      host_inst.mem[base + OFS_OPA + i] = a[8*i +: 8];
      host_inst.mem[base + OFS_OPB + i] = b[8*i +: 8];
      host_inst.mem[base + OFS_EXP + i] = exp_val[8*i +: 8];
    end
  endtask

  task automatic run_card(input logic hang);
    uut_hang = hang;
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    while (active) begin
      @(negedge clk);
    end
  endtask

  task automatic check_echo(input int blk, input operand_t a, input operand_t b,
                            input operand_t exp_val, input operand_t res);
    int base;
    base = blk * BLK;
    for (int i = 0; i < 4; i++) begin
      check_byte($sformatf("blk%0d sig[%0d]", blk, i), host_inst.mem[base + i],
                 GOOD_SIG[8*(3-i) +: 8]);
    end
    check_operand($sformatf("blk%0d opa", blk), get_operand(blk, OFS_OPA), a);
    check_operand($sformatf("blk%0d opb", blk), get_operand(blk, OFS_OPB), b);
    check_operand($sformatf("blk%0d exp", blk), get_operand(blk, OFS_EXP), exp_val);
    check_operand($sformatf("blk%0d res", blk), get_operand(blk, OFS_RES), res);
    for (int i = 28; i < BLK; i++) begin
      check_byte($sformatf("blk%0d pad[%0d]", blk, i), host_inst.mem[base + i], 8'hFF);
    end
  endtask

  task automatic check_timing(input int blk, input logic expect_timeout);
    cycle_count_t cyc;
    cyc = get_cycles(blk);
    checks++;
    if (expect_timeout && cyc <= `AT_TIMEOUT) begin
      errors++;
      $display("blk%0d cycle count %0d does not exceed the timeout", blk, cyc);
    end else if (!expect_timeout && (cyc == 0 || cyc > 100)) begin
      errors++;
      $display("blk%0d cycle count %0d is outside the UUT done window", blk, cyc);
    end
  endtask

  task automatic test_matching_vector();
    operand_t a;
    operand_t b;
    logic [31:0] err_before;
    a = 32'h1234_5678;
    b = 32'h0FED_CBA9;
    fill_card();
    put_vector(0, GOOD_SIG, a, b, a + b);
    put_vector(1, BAD_SIG, a, b, a + b);
    err_before = error_count;
    run_card(1'b0);
    check_count("error_count_o", error_count, err_before);
    check_count("blocks written", host_inst.wr_count, 1);
    check_count("write address 0", host_inst.wr_log[0], block_addr(0));
    check_echo(0, a, b, a + b, a + b);
    check_timing(0, 1'b0);
  endtask

  task automatic test_wrong_expected();
    operand_t a;
    operand_t b;
    logic [31:0] err_before;
    a = 32'h0000_0100;
    b = 32'h0000_0023;
    fill_card();
    put_vector(0, GOOD_SIG, a, b, a + b + 1);
    put_vector(1, GOOD_SIG, a, b, 32'h0);
    put_vector(2, GOOD_SIG, a, b, a + b);
    put_vector(3, BAD_SIG, a, b, a + b);
    err_before = error_count;
    run_card(1'b0);
    check_count("error_count_o", error_count, err_before + 32'd2);
    check_count("blocks written", host_inst.wr_count, 3);
    check_echo(0, a, b, a + b + 1, a + b);
    check_echo(1, a, b, 32'h0, a + b);
  endtask

  // runs after mismatches were counted, so the count is not zero here
  task automatic test_bad_first_signature();
    logic [31:0] err_before;
    fill_card();
    put_vector(0, BAD_SIG, 32'h5, 32'h6, 32'hB);
    err_before = error_count;
    run_card(1'b0);
    check_count("error_count_o", error_count, err_before);
    check_count("blocks written", host_inst.wr_count, 0);
    check_byte("blk0 sig[0] untouched", host_inst.mem[0], BAD_SIG[31:24]);
  endtask

  task automatic test_uut_timeout();
    operand_t a;
    operand_t b;
    logic [31:0] err_before;
    a = 32'h0000_0007;
    b = 32'h0000_0009;
    fill_card();
    put_vector(0, GOOD_SIG, a, b, a + b);
    put_vector(1, BAD_SIG, a, b, a + b);
    err_before = error_count;
    run_card(1'b1);
    check_count("error_count_o", error_count, err_before + 32'd1);
    check_count("blocks written", host_inst.wr_count, 1);
    // a hung UUT never drives its result
    check_echo(0, a, b, a + b, 32'h0);
    check_timing(0, 1'b1);
    uut_hang = 1'b0;
  endtask

  task automatic test_block_sequence();
    operand_t a [0:2];
    operand_t b [0:2];
    logic [31:0] err_before;
    fill_card();
    for (int i = 0; i < 3; i++) begin
      a[i] = $random(seed);
      b[i] = $random(seed);
      put_vector(i, GOOD_SIG, a[i], b[i], a[i] + b[i]);
    end
    put_vector(3, BAD_SIG, 32'h0, 32'h0, 32'h0);
    err_before = error_count;
    run_card(1'b0);
    check_count("error_count_o", error_count, err_before);
    check_count("blocks written", host_inst.wr_count, 3);
    for (int i = 0; i < 3; i++) begin
      check_count($sformatf("write address %0d", i), host_inst.wr_log[i], block_addr(i));
      check_echo(i, a[i], b[i], a[i] + b[i], a[i] + b[i]);
      check_timing(i, 1'b0);
    end
  endtask

  initial begin
    seed = 32'h8ade;
    errors = 0;
    checks = 0;
    rst = 1'b1;
    start = 1'b0;
    uut_hang = 1'b0;
    uut_done = 1'b0;
    uut_result = '0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    test_matching_vector();
    test_wrong_expected();
    test_bad_first_signature();
    test_uut_timeout();
    test_block_sequence();
    check_count("host bad accesses", 32'(host_inst.bad_access), 0);
    check_count("assertion failures",
                autotest_top_inst.autotest_fsm_inst.asserts_inst.fail_count, 0);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* autotest.f */
+incdir+include
hdl/sd_block_pkg.sv
hdl/autotest_pkg.sv
hdl/vector_store.sv
hdl/exec_timer.sv
hdl/autotest_fsm.sv
hdl/autotest_top.sv
verification/sd_host_model.sv
verification/autotest_asserts.sv
verification/autotest_tb.sv
